// File: design/frame_regularizer_core.sv
/*
  Frame state machine of the regularizer, one register stage.
  Emits exactly width x height beats per frame, filling or skipping input.
  Program width and height with update before the first frame,
  since a zero size is not meaningful. Width and height of 1 are allowed.
*/

`timescale 1ns/10ps

module frame_regularizer_core
    import vid_stream_pkg::*;
    import regularizer_ctl_pkg::*;
(
    input  logic         s_axi4s,
    input  logic         rst_n,
    input  pix_beat_t    in_beat,
    input  logic         in_valid,
    output logic         in_ready,
    output pix_beat_t    out_beat,
    output logic         out_valid,
    input  logic         out_ready,
    input  ctl_req_t     ctl,
    input  frame_param_t param,
    output ctl_stat_t    stat
);

    frame_param_t prm;
    frame_param_t act;
    index_t       index;
    logic         busy;
    logic         fill_h;
    logic         fill_v;
    logic         skip;
    width_t       x;
    height_t      y;
    width_t       out_col;

    logic advance;
    logic in_sof;
    logic in_fire;
    logic start;
    logic start_fill;
    logic pix;
    logic drain;
    logic early_sof;
    logic emit;
    logic x_last;
    logic y_last;
    logic pix_timeout_hit;
    logic frame_timeout_hit;

    // --------------------------------------------------
    // decisions
    // --------------------------------------------------
    assign advance = !out_valid || out_ready;

    // new values count already for the first beat of an update frame
    assign act = (!busy && ctl.update) ? param : prm;

    assign x_last = (x == act.width - 1'b1);
    assign y_last = (y == act.height - 1'b1);

    assign in_sof = in_valid && in_beat.sof;

    // a sof inside a frame is held for the next one
    assign in_ready = advance && (busy ? (!in_beat.sof && !fill_v && (skip || !fill_h))
                                       : (!in_beat.sof || ctl.enable));
    assign in_fire  = in_valid && in_ready;

    assign start      = !busy && ctl.enable && (in_sof || frame_timeout_hit);
    assign start_fill = start && !in_sof;
    assign pix        = in_fire && (busy ? !skip : in_beat.sof);
    assign drain      = in_fire && busy && skip;
    assign early_sof  = busy && in_sof && !fill_v;
    assign emit       = start || (busy && (fill_h || fill_v || pix));

    regularizer_timers u_timers (
        .s_axi4s           (s_axi4s),
        .rst_n             (rst_n),
        .advance           (advance),
        .busy              (busy),
        .in_valid          (in_valid),
        .pix_timeout       (prm.pix_timeout),
        .frm_timer_en      (ctl.frm_timer_en),
        .frm_timeout       (ctl.frm_timeout),
        .enable            (ctl.enable),
        .pix_timeout_hit   (pix_timeout_hit),
        .frame_timeout_hit (frame_timeout_hit)
    );

    // --------------------------------------------------
    // frame and line state
    // --------------------------------------------------
    always_ff @(posedge s_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            prm       <= '0;
            index     <= '0;
            busy      <= 1'b0;
            fill_h    <= 1'b0;
            fill_v    <= 1'b0;
            skip      <= 1'b0;
            x         <= '0;
            y         <= '0;
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= emit;

            if (start) begin
                busy   <= !(x_last && y_last);
                fill_v <= start_fill;
                fill_h <= 1'b0;
                skip   <= 1'b0;
                if (ctl.update) begin
                    prm   <= param;
                    index <= index + 1'b1;
                end
            end else if (busy && emit && x_last && y_last) begin
                busy <= 1'b0;
            end

            // rest of the frame becomes fill
            if (busy && (early_sof || pix_timeout_hit)) begin
                fill_v <= 1'b1;
            end

            // short line pads, long line drains to its eol
            if (emit && x_last) begin
                fill_h <= 1'b0;
                skip   <= pix && !in_beat.eol;
            end else if (pix && in_beat.eol) begin
                fill_h <= 1'b1;
            end
            if (drain && in_beat.eol) begin
                skip <= 1'b0;
            end

            if (emit) begin
                if (x_last) begin
                    x <= '0;
                    y <= y_last ? '0 : height_t'(y + 1'b1);
                end else begin
                    x <= x + 1'b1;
                end
            end
        end
    end

    // output register payload
    always_ff @(posedge s_axi4s) begin
        if (advance && emit) begin
            out_beat.sof  <= (x == '0) && (y == '0);
            out_beat.eol  <= x_last;
            out_beat.data <= pix ? in_beat.data : act.fill;
        end
    end

    assign stat = '{busy: busy, index: index, cur_width: prm.width, cur_height: prm.height};

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    // column of the beat on the output port
    always_ff @(posedge s_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            out_col <= '0;
        end else if (out_valid && out_ready) begin
            out_col <= out_beat.eol ? '0 : width_t'(out_col + 1'b1);
        end
    end

    a_eol_last_col: assert property (@(posedge s_axi4s) disable iff (!rst_n)
        out_valid && out_ready |-> out_beat.eol == (out_col == prm.width - 1'b1));

    a_busy_enabled: assert property (@(posedge s_axi4s) disable iff (!rst_n)
        $rose(busy) |-> $past(ctl.enable));

endmodule

// File: design/regularizer_cfg.svh
/*
  Size settings for the video format regularizer.
  Width and height fields must hold the largest programmed frame size.
  Both timers share one counter width.
*/

`ifndef REGULARIZER_CFG_SVH
`define REGULARIZER_CFG_SVH

// --------------------------------------------------
// pixel path
// --------------------------------------------------
`define REG_DATA_BITS   24

// --------------------------------------------------
// frame geometry and control
// --------------------------------------------------
`define REG_WIDTH_BITS  12
`define REG_HEIGHT_BITS 12
`define REG_TIMER_BITS  32

// wraps after 16 parameter updates
`define REG_INDEX_BITS  4

`endif

// File: design/regularizer_ctl_pkg.sv
/*
  Control and frame parameter types of the regularizer.
  frame_param_t is taken only at a frame start while update is high.
  A pixel timeout of zero turns the pixel-gap check off.
*/

`include "regularizer_cfg.svh"

package regularizer_ctl_pkg;

    import vid_stream_pkg::*;

    typedef logic [`REG_WIDTH_BITS-1:0]  width_t;
    typedef logic [`REG_HEIGHT_BITS-1:0] height_t;
    typedef logic [`REG_TIMER_BITS-1:0]  timer_t;
    typedef logic [`REG_INDEX_BITS-1:0]  index_t;

    // --------------------------------------------------
    // per-frame parameters
    // --------------------------------------------------
    typedef struct packed {
        width_t    width;
        height_t   height;
        pix_data_t fill;
        timer_t    pix_timeout;
    } frame_param_t;

    typedef struct packed {
        logic   enable;
        logic   update;
        logic   frm_timer_en;
        timer_t frm_timeout;
    } ctl_req_t;

    typedef struct packed {
        logic    busy;
        index_t  index;
        width_t  cur_width;
        height_t cur_height;
    } ctl_stat_t;

endpackage

// File: design/regularizer_timers.sv
/*
  Pixel-gap and idle-frame timers of the regularizer.
  Both count only on advancing cycles, and a hit holds until the
  next advancing cycle so the core sees it exactly once.
*/

`timescale 1ns/10ps

module regularizer_timers
    import regularizer_ctl_pkg::*;
(
    input  logic   s_axi4s,
    input  logic   rst_n,
    input  logic   advance,
    input  logic   busy,
    input  logic   in_valid,
    input  timer_t pix_timeout,
    input  logic   frm_timer_en,
    input  timer_t frm_timeout,
    input  logic   enable,
    output logic   pix_timeout_hit,
    output logic   frame_timeout_hit
);

    timer_t pix_cnt;
    timer_t frm_cnt;

    always_ff @(posedge s_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt           <= '0;
            frm_cnt           <= '0;
            pix_timeout_hit   <= 1'b0;
            frame_timeout_hit <= 1'b0;
        end else if (advance) begin
            // gap between input beats inside a frame
            pix_timeout_hit <= 1'b0;
            if (!busy || in_valid) begin
                pix_cnt <= '0;
            end else begin
                pix_cnt <= pix_cnt + 1'b1;
                if (pix_timeout != '0 && pix_cnt == pix_timeout) begin
                    pix_timeout_hit <= 1'b1;
                end
            end

            // no start of frame for too long
            frame_timeout_hit <= 1'b0;
            if (enable && frm_timer_en && !busy) begin
                frm_cnt <= frm_cnt + 1'b1;
                if (frm_cnt == frm_timeout) begin
                    frame_timeout_hit <= 1'b1;
                end
            end else begin
                frm_cnt <= '0;
            end
        end
    end

endmodule

// File: design/stream_skid_ff.sv
/*
  Two-entry valid/ready buffer with a registered ready.
  No combinational path from m_ready to s_ready.
  s_ready is low for one cycle after reset.
*/

`timescale 1ns/10ps

module stream_skid_ff
    import vid_stream_pkg::*;
#(
    parameter type data_t = pix_beat_t
) (
    input  logic  s_axi4s,
    input  logic  rst_n,
    input  data_t s_data,
    input  logic  s_valid,
    output logic  s_ready,
    output data_t m_data,
    output logic  m_valid,
    input  logic  m_ready
);

    logic  main_v;
    logic  skid_v;
    data_t main_q;
    data_t skid_q;
    logic  in_fire;
    logic  pop;

    assign in_fire = s_valid && s_ready;
    // main register is free or is being taken
    assign pop     = !main_v || m_ready;

    always_ff @(posedge s_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            main_v  <= 1'b0;
            skid_v  <= 1'b0;
            s_ready <= 1'b0;
        end else begin
            if (pop) begin
                main_v  <= skid_v || in_fire;
                skid_v  <= 1'b0;
                s_ready <= 1'b1;
            end else if (in_fire) begin
                skid_v  <= 1'b1;
                s_ready <= 1'b0;
            end else begin
                s_ready <= !skid_v;
            end
        end
    end

    always_ff @(posedge s_axi4s) begin
        if (pop) begin
            main_q <= skid_v ? skid_q : s_data;
        end
        // output stalled, park the new beat
        if (!pop && in_fire) begin
            skid_q <= s_data;
        end
    end

    assign m_valid = main_v;
    assign m_data  = main_q;

    a_hold_stable: assert property (@(posedge s_axi4s) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

// File: design/vid_stream_pkg.sv
/*
  Pixel stream types, one pixel per beat.
  sof marks the first pixel of a frame and eol the last pixel of a line.
  The user field is the single sof bit.
*/

`include "regularizer_cfg.svh"

package vid_stream_pkg;

    // one pixel
    typedef logic [`REG_DATA_BITS-1:0] pix_data_t;

    // --------------------------------------------------
    // stream beat, carried on every valid/ready link
    // --------------------------------------------------
    typedef struct packed {
        logic      sof;
        logic      eol;
        pix_data_t data;
    } pix_beat_t;

endpackage

// File: design/video_format_regularizer.sv
/*
  Video format regularizer top, one pixel per beat.
  Latency is 3 cycles without back-pressure.
  ctl and param must be held static between frame starts.
*/

`timescale 1ns/10ps

module video_format_regularizer
    import vid_stream_pkg::*;
    import regularizer_ctl_pkg::*;
(
    input  logic         s_axi4s,
    input  logic         rst_n,
    input  pix_beat_t    s_beat,
    input  logic         s_valid,
    output logic         s_ready,
    output pix_beat_t    m_beat,
    output logic         m_valid,
    input  logic         m_ready,
    input  ctl_req_t     ctl,
    input  frame_param_t param,
    output ctl_stat_t    stat
);

    pix_beat_t in_beat;
    logic      in_valid;
    logic      in_ready;
    pix_beat_t core_beat;
    logic      core_valid;
    logic      core_ready;

    stream_skid_ff #(.data_t(pix_beat_t)) skid_in (
        .s_axi4s (s_axi4s),
        .rst_n   (rst_n),
        .s_data  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_data  (in_beat),
        .m_valid (in_valid),
        .m_ready (in_ready)
    );

    frame_regularizer_core core0 (
        .s_axi4s   (s_axi4s),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (core_beat),
        .out_valid (core_valid),
        .out_ready (core_ready),
        .ctl       (ctl),
        .param     (param),
        .stat      (stat)
    );

    stream_skid_ff #(.data_t(pix_beat_t)) skid_out (
        .s_axi4s (s_axi4s),
        .rst_n   (rst_n),
        .s_data  (core_beat),
        .s_valid (core_valid),
        .s_ready (core_ready),
        .m_data  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the regularizer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_regularizer -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// File: sim/regularizer_checker.sv
/*
  Output checker of the regularizer testbench.
  Frames must be announced in the order they leave the DUT, and the
  line lengths of a frame are added before the frame is announced.
  Pixel data of input line l, column c in frame f is {f, l, c}, 8 bits each.
*/

`timescale 1ns/10ps

module regularizer_checker
    import vid_stream_pkg::*;
    import regularizer_ctl_pkg::*;
(
    input logic      s_axi4s,
    input logic      rst_n,
    input pix_beat_t m_beat,
    input logic      m_valid,
    input logic      m_ready,
    input ctl_stat_t stat
);

    int        errors = 0;
    int        lens_q[$];
    pix_beat_t exp_q[$];
    pix_beat_t exp_b;

    function automatic pix_data_t pixel_value(int frame_id, int line, int col);
        return {frame_id[7:0], line[7:0], col[7:0]};
    endfunction

    // --------------------------------------------------
    // reference model of one output beat
    // --------------------------------------------------
    function automatic pix_beat_t expected_beat(int frame_id, int row, int col, int width,
                                                pix_data_t fill);
        pix_beat_t b;
        int        len;
        b.sof  = (row == 0) && (col == 0);
        b.eol  = (col == width - 1);
        len    = (row < lens_q.size()) ? lens_q[row] : 0;
        // col stays below width, so this is min(len, width) input pixels
        b.data = (col < len) ? pixel_value(frame_id, row, col) : fill;
        return b;
    endfunction

    task automatic add_line(int len);
        lens_q.push_back(len);
    endtask

    task automatic expect_frame(int frame_id, int width, int height, pix_data_t fill);
        for (int r = 0; r < height; r++) begin
            for (int c = 0; c < width; c++) begin
                exp_q.push_back(expected_beat(frame_id, r, c, width, fill));
            end
        end
        lens_q.delete();
    endtask

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    task automatic value_error(string name, logic [31:0] exp_v, logic [31:0] act_v);
        errors++;
        $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp_v, act_v);
    endtask

    // status between frames, with the DUT idle
    task automatic check_stat(index_t exp_index, width_t exp_width, height_t exp_height);
        if (stat.busy != 1'b0) value_error("stat.busy", 32'd0, 32'(stat.busy));
        if (stat.index != exp_index) value_error("stat.index", 32'(exp_index), 32'(stat.index));
        if (stat.cur_width != exp_width) begin
            value_error("stat.cur_width", 32'(exp_width), 32'(stat.cur_width));
        end
        if (stat.cur_height != exp_height) begin
            value_error("stat.cur_height", 32'(exp_height), 32'(stat.cur_height));
        end
    endtask

    // --------------------------------------------------
    // compare every output transfer
    // --------------------------------------------------
    always @(posedge s_axi4s) begin
        if (rst_n && m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error at %0t ns: output beat arrived when none was expected", $time);
            end else begin
                exp_b = exp_q.pop_front();
                if (m_beat.sof != exp_b.sof) begin
                    value_error("m_beat.sof", 32'(exp_b.sof), 32'(m_beat.sof));
                end
                if (m_beat.eol != exp_b.eol) begin
                    value_error("m_beat.eol", 32'(exp_b.eol), 32'(m_beat.eol));
                end
                if (m_beat.data != exp_b.data) begin
                    value_error("m_beat.data", 32'(exp_b.data), 32'(m_beat.data));
                end
            end
        end
    end

endmodule

// File: sim/tb_regularizer.sv
/*
  Testbench of the video format regularizer.
  Inputs change on the falling clock edge only.
  Every wait gives up after a cycle limit and ends the run.
*/

`timescale 1ns/10ps

`include "regularizer_cfg.svh"

module tb_regularizer
    import vid_stream_pkg::*;
    import regularizer_ctl_pkg::*;
;

    logic         s_axi4s;
    logic         rst_n;
    pix_beat_t    s_beat;
    logic         s_valid;
    logic         s_ready;
    pix_beat_t    m_beat;
    logic         m_valid;
    logic         m_ready;
    ctl_req_t     ctl;
    frame_param_t param;
    ctl_stat_t    stat;

    logic [31:0] rng_len;
    logic [31:0] rng_bp;
    logic        bp_on;
    int          lens [0:15];
    int          frame_id;
    int          err_mark;
    int          tests_run;
    int          tests_failed;
    index_t      exp_index;
    logic [`REG_DATA_BITS-1:0] fill_a;

    video_format_regularizer dut0 (
        .s_axi4s (s_axi4s), .rst_n (rst_n),
        .s_beat (s_beat), .s_valid (s_valid), .s_ready (s_ready),
        .m_beat (m_beat), .m_valid (m_valid), .m_ready (m_ready),
        .ctl (ctl), .param (param), .stat (stat)
    );

    regularizer_checker chk0 (
        .s_axi4s (s_axi4s), .rst_n (rst_n),
        .m_beat (m_beat), .m_valid (m_valid), .m_ready (m_ready),
        .stat (stat)
    );

    initial begin
        s_axi4s = 1'b0;
        forever #10 s_axi4s = ~s_axi4s;
    end

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // output back-pressure
    always @(negedge s_axi4s) begin
        rng_bp  <= lcg_next(rng_bp);
        m_ready <= bp_on ? rng_bp[20] : 1'b1;
    end

    task automatic give_up(string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic send_beat(pix_beat_t b);
        int cnt;
        cnt     = 0;
        s_beat  = b;
        s_valid = 1'b1;
        while (!s_ready) begin
            @(negedge s_axi4s);
            cnt++;
            if (cnt > 2000) give_up("input never became ready");
        end
        @(negedge s_axi4s);
        s_valid = 1'b0;
    endtask

    // lines 0..n_lines-1 first, then the expected frame
    task automatic announce_frame(int n_lines, int width, int height, pix_data_t fill);
        for (int l = 0; l < n_lines; l++) begin
            chk0.add_line(lens[l]);
        end
        chk0.expect_frame(frame_id, width, height, fill);
    endtask

    // sends lines 0..n_lines-1 with lengths from lens
    task automatic send_frame(int n_lines);
        pix_beat_t b;
        for (int l = 0; l < n_lines; l++) begin
            for (int c = 0; c < lens[l]; c++) begin
                b.sof  = (l == 0) && (c == 0);
                b.eol  = (c == lens[l] - 1);
                b.data = chk0.pixel_value(frame_id, l, c);
                send_beat(b);
            end
        end
    endtask

    task automatic random_lens(int n);
        for (int l = 0; l < n; l++) begin
            rng_len = lcg_next(rng_len);
            lens[l] = 1 + int'(rng_len[23:16] % 8'd14);
        end
    endtask

    task automatic wait_drain(string what);
        int cnt;
        cnt = 0;
        while (chk0.pending_count() != 0) begin
            @(negedge s_axi4s);
            cnt++;
            if (cnt > 5000) give_up(what);
        end
        frame_id++;
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (chk0.errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, chk0.errors - err_mark);
        end
        err_mark = chk0.errors;
    endtask

    initial begin
        rst_n   = 1'b0;
        s_beat  = '0;
        s_valid = 1'b0;
        m_ready = 1'b1;
        ctl     = '0;
        param   = '0;
        rng_len = 32'h4d3e;
        rng_bp  = 32'h4d3e;
        bp_on   = 1'b0;
        frame_id = 1;
        err_mark = 0;
        tests_run = 0;
        tests_failed = 0;
        exp_index = '0;
        fill_a = `REG_DATA_BITS'h0f0f0f;
        repeat (2) @(negedge s_axi4s);
        rst_n = 1'b1;

        // --------------------------------------------------
        // exact frame with a parameter update
        // --------------------------------------------------
        ctl.enable = 1'b1;
        ctl.update = 1'b1;
        param = '{width: 8, height: 4, fill: fill_a, pix_timeout: 0};
        for (int l = 0; l < 4; l++) lens[l] = 8;
        announce_frame(4, 8, 4, fill_a);
        send_frame(4);
        wait_drain("exact frame not delivered");
        ctl.update = 1'b0;
        exp_index++;
        chk0.check_stat(exp_index, 8, 4);
        end_test("exact frame");

        // short and long lines
        for (int f = 0; f < 3; f++) begin
            random_lens(4);
            announce_frame(4, 8, 4, fill_a);
            send_frame(4);
            wait_drain("padded frame not delivered");
        end
        end_test("pad and truncate");

        // --------------------------------------------------
        // missing lines, then excess lines
        // --------------------------------------------------
        random_lens(2);
        announce_frame(2, 8, 4, fill_a);
        send_frame(2);
        frame_id++;
        random_lens(4);
        announce_frame(4, 8, 4, fill_a);
        send_frame(4);
        wait_drain("frame after a short frame not delivered");
        random_lens(7);
        announce_frame(7, 8, 4, fill_a);
        send_frame(7);
        frame_id++;
        random_lens(4);
        announce_frame(4, 8, 4, fill_a);
        send_frame(4);
        wait_drain("frame after a tall frame not delivered");
        end_test("line count");

        bp_on = 1'b1;
        for (int f = 0; f < 4; f++) begin
            random_lens(5);
            announce_frame(5, 8, 4, fill_a);
            send_frame(5);
            wait_drain("frame under back-pressure not delivered");
        end
        bp_on = 1'b0;
        end_test("back-pressure");

        // --------------------------------------------------
        // parameters change only with update
        // --------------------------------------------------
        param = '{width: 10, height: 3, fill: 24'h00aa55, pix_timeout: 0};
        random_lens(4);
        announce_frame(4, 8, 4, fill_a);
        send_frame(4);
        wait_drain("frame with held parameters not delivered");
        chk0.check_stat(exp_index, 8, 4);
        ctl.update = 1'b1;
        random_lens(3);
        announce_frame(3, 10, 3, 24'h00aa55);
        send_frame(3);
        wait_drain("frame with new parameters not delivered");
        ctl.update = 1'b0;
        exp_index++;
        chk0.check_stat(exp_index, 10, 3);
        end_test("parameter update");

        // pixel timeout, then the idle-frame timer
        ctl.update = 1'b1;
        param = '{width: 6, height: 4, fill: 24'h123456, pix_timeout: 12};
        for (int l = 0; l < 2; l++) lens[l] = 6;
        announce_frame(2, 6, 4, 24'h123456);
        send_frame(2);
        wait_drain("stalled frame was not filled");
        ctl.update = 1'b0;
        exp_index++;
        ctl.frm_timeout  = 30;
        ctl.frm_timer_en = 1'b1;
        chk0.expect_frame(frame_id, 6, 4, 24'h123456);
        wait_drain("frame timer produced no fill frame");
        ctl.frm_timer_en = 1'b0;
        chk0.check_stat(exp_index, 6, 4);
        end_test("timeouts");

        // stray beats would show up here
        repeat (20) @(negedge s_axi4s);
        if (chk0.errors != err_mark) tests_failed++;
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, chk0.errors);
        if (tests_failed == 0 && chk0.errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+design
design/vid_stream_pkg.sv
design/regularizer_ctl_pkg.sv
design/stream_skid_ff.sv
design/regularizer_timers.sv
design/frame_regularizer_core.sv
design/video_format_regularizer.sv
sim/regularizer_checker.sv
sim/tb_regularizer.sv
